// File: jtag_dbg.f
hdl/jtag_dbg_pkg.sv
hdl/tck_sampler.sv
hdl/dr_shifter.sv
hdl/dbg_wb_master.sv
hdl/dbg_mailbox.sv
hdl/jtag_dbg_top.sv
verification/tb_clkgen.sv
verification/jtag_dbg_checker.sv
verification/jtag_dbg_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the jtag_dbg testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f jtag_dbg.f --top-module jtag_dbg_tb -o jtag_dbg_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/jtag_dbg_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0

// File: verification/jtag_dbg_tb.sv
/* jtag debug path testbench */
`timescale 1ns/1ps

module jtag_dbg_tb;

	import jtag_dbg_pkg::*;

	localparam int DR_WIDTH   = DBG_DR_WIDTH_DEF;
	localparam int N_RANDOM   = 40;
	localparam int N_SCANS    = N_RANDOM + 5; // two full, one partial, two around the reset
	localparam int MAX_CYCLES = N_SCANS * 40 * 12 + 1000;
	localparam int TCK_HALF   = 6; // clk48m cycles per tck phase

	logic                clk48m;
	logic                por_rstn;
	logic                mid_rstn;
	logic                jrstn;
	logic                jtck;
	logic                jtdi;
	logic                jshift;
	logic                jupdate;
	logic                jce1;
	logic                jce2;
	logic [DR_WIDTH-1:0] dbg_reg_a;
	logic [DR_WIDTH-1:0] dbg_reg_b;
	dbg_reg_e            dbg_sel;
	logic                dbg_strobe;
	logic [31:0]         rng;
	int                  tb_errs;
	int                  tests;
	int                  cycles = 0;

	assign jrstn = por_rstn & mid_rstn; // power-on plus the mid-run pulse

	tb_clkgen u_clk (.clk48m(clk48m), .jrstn(por_rstn));

	jtag_dbg_top #(.DR_WIDTH(DR_WIDTH)) UUT (
		.clk48m(clk48m), .jrstn(jrstn), .jtck(jtck), .jtdi(jtdi),
		.jshift(jshift), .jupdate(jupdate), .jce1(jce1), .jce2(jce2),
		.dbg_reg_a(dbg_reg_a), .dbg_reg_b(dbg_reg_b),
		.dbg_sel(dbg_sel), .dbg_strobe(dbg_strobe)
	);

	jtag_dbg_checker #(.DR_WIDTH(DR_WIDTH)) chk (
		.clk48m(clk48m), .jrstn(jrstn), .jtck(jtck), .jtdi(jtdi),
		.jshift(jshift), .jupdate(jupdate), .jce1(jce1), .jce2(jce2),
		.dbg_reg_a(dbg_reg_a), .dbg_reg_b(dbg_reg_b),
		.dbg_sel(dbg_sel), .dbg_strobe(dbg_strobe)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_word(output logic [DR_WIDTH-1:0] w);
		int i;
		for (i = 0; i < DR_WIDTH; i++) begin
			if (i % 32 == 0)
				rng = xorshift32(rng); // fresh 32 bits per slice
			w[i] = rng[i % 32];
		end
	endtask

	// pins change with tck low, then tck rises half a period later
	task automatic tck_edge(input logic tdi, input logic shift, input logic update,
			input logic ce1, input logic ce2);
		jtck    = 1'b0;
		jtdi    = tdi;
		jshift  = shift;
		jupdate = update;
		jce1    = ce1;
		jce2    = ce2;
		repeat (TCK_HALF) @(posedge clk48m);
		#10 jtck = 1'b1;
		repeat (TCK_HALF) @(posedge clk48m);
		#10;
	endtask

	task automatic drive_idle();
		jtck    = 1'b0;
		jtdi    = 1'b0;
		jshift  = 1'b0;
		jupdate = 1'b0;
		jce1    = 1'b0;
		jce2    = 1'b0;
		repeat (TCK_HALF) @(posedge clk48m);
		#10;
	endtask

	function automatic int err_total();
		return chk.err_count + tb_errs;
	endfunction

	// waits for the checker to see every strobe it expects
	task automatic wait_drain();
		int n;
		n = 0;
		while (chk.outstanding != 0 && n < 40) begin
			@(posedge clk48m);
			#10 n++;
		end
		if (chk.outstanding != 0) begin
			tb_errs++;
			$display("transfer still outstanding 40 cycles after the update");
		end
	endtask

	// capture edge, len shift edges lsb first, then update
	task automatic run_scan(input logic [DR_WIDTH-1:0] word, input int len,
			input logic chain_b);
		int k;
		tck_edge(1'b0, len > 0, 1'b0, !chain_b, chain_b);
		for (k = 1; k <= len; k++)
			tck_edge(word[k-1], k < len, 1'b0, !chain_b, chain_b);
		tck_edge(1'b0, 1'b0, 1'b1, 1'b0, 1'b0); // update-dr
		drive_idle();
		wait_drain();
	endtask

	task automatic finish_test(input string name, input int base);
		tests++;
		if (err_total() == base)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: FAIL, %0d errors", tests, name, err_total() - base);
	endtask

	// hard stop if anything stalls
	always @(posedge clk48m) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run still going after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		int                  base;
		int                  i;
		int                  len;
		logic                chain_b;
		logic [DR_WIDTH-1:0] word;
		jtck     = 1'b0;
		jtdi     = 1'b0;
		jshift   = 1'b0;
		jupdate  = 1'b0;
		jce1     = 1'b0;
		jce2     = 1'b0;
		mid_rstn = 1'b1;
		rng      = 32'h1669_bb00;
		tb_errs  = 0;
		tests    = 0;

		base = err_total(); // checker looks at the outputs on release
		wait (por_rstn === 1'b1);
		@(posedge clk48m);
		#10;
		repeat (4) @(posedge clk48m);
		#10 finish_test("reset state", base);

		base = err_total();
		next_word(word);
		run_scan(word, DR_WIDTH, 1'b0);
		finish_test("full scan chain a", base);

		base = err_total();
		next_word(word);
		run_scan(word, DR_WIDTH, 1'b1);
		finish_test("full scan chain b", base);

		base = err_total();
		rng = xorshift32(rng);
		len = 1 + int'(rng[31:8]) % (DR_WIDTH - 1);
		chain_b = rng[0];
		next_word(word);
		run_scan(word, len, chain_b);
		finish_test("partial scan", base);

		base = err_total();
		for (i = 0; i < N_RANDOM; i++) begin
			rng = xorshift32(rng);
			chain_b = rng[0];
			if (rng[3:1] == 3'd0)
				len = 0; // update alone, same word again
			else
				len = 1 + int'(rng[31:8]) % DR_WIDTH;
			next_word(word);
			run_scan(word, len, chain_b);
		end
		finish_test("random scans", base);

		base = err_total();
		next_word(word);
		run_scan(word, DR_WIDTH, 1'b1); // select on b and both registers loaded
		mid_rstn = 1'b0;
		repeat (2) @(posedge clk48m);
		#10 mid_rstn = 1'b1;
		repeat (2) @(posedge clk48m);
		#10;
		next_word(word);
		run_scan(word, 8, 1'b1); // upper bits new, rest from the cleared register
		finish_test("mid-run reset", base);

		$display("tests %0d, checks %0d, errors %0d", tests, chk.check_count, err_total());
		if (err_total() == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verification/jtag_dbg_checker.sv
/* register path model and checker */
`timescale 1ns/1ps

module jtag_dbg_checker #(
	parameter int DR_WIDTH    = jtag_dbg_pkg::DBG_DR_WIDTH_DEF,
	parameter int STROBE_WAIT = 20 // cycles allowed from update edge to strobe
) (
	input logic                   clk48m,
	input logic                   jrstn,
	input logic                   jtck,
	input logic                   jtdi,
	input logic                   jshift,
	input logic                   jupdate,
	input logic                   jce1,
	input logic                   jce2,
	input logic [DR_WIDTH-1:0]    dbg_reg_a,
	input logic [DR_WIDTH-1:0]    dbg_reg_b,
	input jtag_dbg_pkg::dbg_reg_e dbg_sel,
	input logic                   dbg_strobe
);

	import jtag_dbg_pkg::*;

	logic [DR_WIDTH-1:0] m_shreg;     // model scan register
	logic                m_old_shift; // shift enable from the previous tck edge
	dbg_reg_e            m_chain;     // chain picked by the last ce
	logic [DR_WIDTH-1:0] m_reg_a;
	logic [DR_WIDTH-1:0] m_reg_b;
	logic [DR_WIDTH-1:0] exp_word[$]; // updates still waiting for their strobe
	dbg_reg_e            exp_sel[$];
	int                  exp_cyc[$];  // cycle of each update edge
	logic                prev_tck;
	logic                prev_rst;
	int                  cyc;
	int                  check_count;
	int                  err_count;
	int                  outstanding; // read by the testbench top

	initial begin
		prev_tck    = 1'b0;
		prev_rst    = 1'b0;
		cyc         = 0;
		check_count = 0;
		err_count   = 0;
		outstanding = 0;
	end

	task automatic compare(input string name, input logic [DR_WIDTH-1:0] got,
			input logic [DR_WIDTH-1:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_sel(input dbg_reg_e exp);
		check_count++;
		if (dbg_sel !== exp) begin
			err_count++;
			$display("MISMATCH dbg_sel: got %h expected %h", dbg_sel, exp);
		end
	endtask

	always @(posedge clk48m) begin
		logic [DR_WIDTH-1:0] w;
		dbg_reg_e            s;
		cyc++;
		if (!jrstn) begin
			m_shreg     = '0;
			m_old_shift = 1'b0;
			m_chain     = DBG_REG_A;
			m_reg_a     = '0;
			m_reg_b     = '0;
			exp_word.delete();
			exp_sel.delete();
			exp_cyc.delete();
			prev_rst = 1'b1;
			prev_tck = jtck;
		end else begin
			if (prev_rst) begin // first cycle out of reset, everything cleared
				compare("dbg_reg_a", dbg_reg_a, '0);
				compare("dbg_reg_b", dbg_reg_b, '0);
				compare_sel(DBG_REG_A);
				check_count++;
				if (dbg_strobe !== 1'b0) begin
					err_count++;
					$display("dbg_strobe is high right after reset");
				end
			end
			if (dbg_strobe) begin
				if (exp_word.size() == 0) begin
					err_count++;
					$display("dbg_strobe seen with no update outstanding");
				end else begin
					w = exp_word.pop_front();
					s = exp_sel.pop_front();
					void'(exp_cyc.pop_front());
					if (s == DBG_REG_B)
						m_reg_b = w;
					else
						m_reg_a = w;
					compare_sel(s);
					compare("dbg_reg_a", dbg_reg_a, m_reg_a);
					compare("dbg_reg_b", dbg_reg_b, m_reg_b);
				end
			end else if (exp_cyc.size() != 0 && cyc - exp_cyc[0] > STROBE_WAIT) begin
				err_count++;
				$display("no dbg_strobe within %0d cycles of a jupdate edge", STROBE_WAIT);
				w = exp_word.pop_front();
				s = exp_sel.pop_front();
				void'(exp_cyc.pop_front());
				if (s == DBG_REG_B) // keep the expected state moving
					m_reg_b = w;
				else
					m_reg_a = w;
			end
			// jtag rules on each tck rising edge
			if (jtck && !prev_tck) begin
				if (jupdate) begin // word and chain as they were before this edge
					exp_word.push_back(m_shreg);
					exp_sel.push_back(m_chain);
					exp_cyc.push_back(cyc);
				end
				if (m_old_shift)
					m_shreg = {jtdi, m_shreg[DR_WIDTH-1:1]};
				if (jce1 || jce2)
					m_chain = jce2 ? DBG_REG_B : DBG_REG_A;
				m_old_shift = jshift;
			end
			prev_tck = jtck;
			prev_rst = 1'b0;
		end
		outstanding = exp_word.size();
	end

endmodule

// File: verification/tb_clkgen.sv
/* testbench clock and reset */
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int HALF_PERIOD = 50, // 100 ns clock
	parameter int RST_CYCLES  = 3
) (
	output logic clk48m,
	output logic jrstn // power-on reset, low for RST_CYCLES edges
);

	initial begin
		clk48m = 1'b0;
		forever #HALF_PERIOD clk48m = ~clk48m;
	end

	initial begin
		jrstn = 1'b0;
		repeat (RST_CYCLES) @(posedge clk48m);
		#10 jrstn = 1'b1; // released off the edge like every other input
	end

endmodule

// File: hdl/jtag_dbg_top.sv
/* jtag debug data register path */
`timescale 1ns/1ps

module jtag_dbg_top #(
	parameter int DR_WIDTH = jtag_dbg_pkg::DBG_DR_WIDTH_DEF
) (
	input  logic                   clk48m,
	input  logic                   jrstn,
	input  logic                   jtck,
	input  logic                   jtdi,
	input  logic                   jshift,
	input  logic                   jupdate,
	input  logic                   jce1,   // IR 0x32 selected
	input  logic                   jce2,   // IR 0x38 selected
	output logic [DR_WIDTH-1:0]    dbg_reg_a,
	output logic [DR_WIDTH-1:0]    dbg_reg_b,
	output jtag_dbg_pkg::dbg_reg_e dbg_sel,
	output logic                   dbg_strobe
);

	import jtag_dbg_pkg::*;

	// sampler to shifter
	logic tck_rise, s_tdi, s_shift, s_update, s_ce1, s_ce2;
	// shifter to bus master
	logic                dr_valid;
	logic [DR_WIDTH-1:0] dr_word;
	dbg_reg_e            dr_sel;
	// wishbone
	logic                wb_cyc, wb_stb, wb_we, wb_adr, wb_ack;
	logic [DR_WIDTH-1:0] wb_dat_w;

	tck_sampler u_sampler (
		.clk48m(clk48m), .jrstn(jrstn),
		.jtck(jtck), .jtdi(jtdi), .jshift(jshift), .jupdate(jupdate),
		.jce1(jce1), .jce2(jce2),
		.tck_rise(tck_rise), .s_tdi(s_tdi), .s_shift(s_shift),
		.s_update(s_update), .s_ce1(s_ce1), .s_ce2(s_ce2)
	);

	dr_shifter #(.DR_WIDTH(DR_WIDTH)) u_shifter (
		.clk48m(clk48m), .jrstn(jrstn), .tck_rise(tck_rise),
		.s_tdi(s_tdi), .s_shift(s_shift), .s_update(s_update),
		.s_ce1(s_ce1), .s_ce2(s_ce2),
		.dr_valid(dr_valid), .dr_word(dr_word), .dr_sel(dr_sel)
	);

	dbg_wb_master #(.DR_WIDTH(DR_WIDTH)) u_master (
		.clk48m(clk48m), .jrstn(jrstn),
		.dr_valid(dr_valid), .dr_word(dr_word), .dr_sel(dr_sel),
		.wb_ack(wb_ack), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w)
	);

	dbg_mailbox #(.DR_WIDTH(DR_WIDTH)) u_mailbox (
		.clk48m(clk48m), .jrstn(jrstn),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
		.dbg_reg_a(dbg_reg_a), .dbg_reg_b(dbg_reg_b),
		.dbg_sel(dbg_sel), .dbg_strobe(dbg_strobe)
	);

endmodule

// File: hdl/dbg_mailbox.sv
/* debug mailbox, wishbone slave */
`timescale 1ns/1ps

module dbg_mailbox #(
	parameter int DR_WIDTH = jtag_dbg_pkg::DBG_DR_WIDTH_DEF
) (
	input  logic                   clk48m,
	input  logic                   jrstn,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic                   wb_adr,
	input  logic [DR_WIDTH-1:0]    wb_dat_w,
	output logic                   wb_ack,     // registered, one cycle
	output logic [DR_WIDTH-1:0]    dbg_reg_a,
	output logic [DR_WIDTH-1:0]    dbg_reg_b,
	output jtag_dbg_pkg::dbg_reg_e dbg_sel,    // last register written
	output logic                   dbg_strobe  // one cycle per write
);

	import jtag_dbg_pkg::*;

	logic req; // new request, not yet acked

	assign req = wb_cyc & wb_stb & ~wb_ack;

	always_ff @(posedge clk48m) begin
		dbg_strobe <= 1'b0;
		if (!jrstn) begin
			wb_ack    <= 1'b0;
			dbg_reg_a <= '0;
			dbg_reg_b <= '0;
			dbg_sel   <= DBG_REG_A;
		end else begin
			wb_ack <= req; // ack lands the cycle after stb is first seen
			if (req && wb_we) begin
				// register changes together with the ack
				if (wb_adr == DBG_ADR_B)
					dbg_reg_b <= wb_dat_w;
				else
					dbg_reg_a <= wb_dat_w;
				dbg_sel    <= (wb_adr == DBG_ADR_B) ? DBG_REG_B : DBG_REG_A;
				dbg_strobe <= 1'b1;
			end
		end
	end

	// master must keep the request up through the ack cycle
	a_ack_in_cycle: assert property (@(posedge clk48m) disable iff (!jrstn)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

// File: hdl/dbg_wb_master.sv
/* wishbone write master */
`timescale 1ns/1ps

module dbg_wb_master #(
	parameter int DR_WIDTH = jtag_dbg_pkg::DBG_DR_WIDTH_DEF
) (
	input  logic                   clk48m,
	input  logic                   jrstn,
	input  logic                   dr_valid,
	input  logic [DR_WIDTH-1:0]    dr_word,
	input  jtag_dbg_pkg::dbg_reg_e dr_sel,
	input  logic                   wb_ack,
	output logic                   wb_cyc,
	output logic                   wb_stb,
	output logic                   wb_we,
	output logic                   wb_adr,   // word address, one bit
	output logic [DR_WIDTH-1:0]    wb_dat_w
);

	import jtag_dbg_pkg::*;

	wb_state_e           wb_state;
	logic                pend_valid; // one item parked while the bus is busy
	logic [DR_WIDTH-1:0] pend_word;
	dbg_reg_e            pend_sel;
	logic                issue;      // start a cycle this clock
	logic [DR_WIDTH-1:0] iss_word;
	dbg_reg_e            iss_sel;

	// parked item goes first, else straight from the shifter
	assign issue    = (wb_state == WB_IDLE) && (pend_valid || dr_valid);
	assign iss_word = pend_valid ? pend_word : dr_word;
	assign iss_sel  = pend_valid ? pend_sel : dr_sel;

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			wb_state   <= WB_IDLE;
			wb_cyc     <= 1'b0;
			wb_stb     <= 1'b0;
			wb_we      <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			case (wb_state)
				WB_IDLE: begin
					if (issue) begin
						wb_cyc   <= 1'b1;
						wb_stb   <= 1'b1;
						wb_we    <= 1'b1; // write only, nothing reads the mailbox
						wb_state <= WB_BUS;
					end
					// a new arrival takes the slot freed by the drain
					if (pend_valid)
						pend_valid <= dr_valid;
				end
				WB_BUS: begin
					if (wb_ack) begin // drop on the edge that sees ack
						wb_cyc   <= 1'b0;
						wb_stb   <= 1'b0;
						wb_we    <= 1'b0;
						wb_state <= WB_IDLE;
					end
					if (dr_valid)
						pend_valid <= 1'b1;
				end
				default: wb_state <= WB_IDLE;
			endcase
		end
	end

	// payload, held from issue until after ack
	always_ff @(posedge clk48m) begin
		if (dr_valid) begin
			pend_word <= dr_word;
			pend_sel  <= dr_sel;
		end
		if (issue) begin
			wb_dat_w <= iss_word;
			wb_adr   <= (iss_sel == DBG_REG_B) ? DBG_ADR_B : DBG_ADR_A;
		end
	end

	a_stb_hold: assert property (@(posedge clk48m) disable iff (!jrstn)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_dat_w) && $stable(wb_adr));
	// buffer full means bus busy and an item already parked
	a_no_overrun: assert property (@(posedge clk48m) disable iff (!jrstn)
		dr_valid |-> !(pend_valid && wb_state == WB_BUS));

endmodule

// File: hdl/dr_shifter.sv
/* jtag data register */
`timescale 1ns/1ps

module dr_shifter #(
	parameter int DR_WIDTH = jtag_dbg_pkg::DBG_DR_WIDTH_DEF
) (
	input  logic                   clk48m,
	input  logic                   jrstn,
	input  logic                   tck_rise, // from the sampler
	input  logic                   s_tdi,
	input  logic                   s_shift,
	input  logic                   s_update,
	input  logic                   s_ce1,
	input  logic                   s_ce2,
	output logic                   dr_valid, // one cycle per update
	output logic [DR_WIDTH-1:0]    dr_word,
	output jtag_dbg_pkg::dbg_reg_e dr_sel
);

	import jtag_dbg_pkg::*;

	logic [DR_WIDTH-1:0] shreg;     // the scan register itself
	logic                old_shift; // shift enable seen on the previous tck edge
	dbg_reg_e            chain_sel; // chain picked by the last ce pulse

	// control path, everything moves on tck_rise only
	always_ff @(posedge clk48m) begin
		dr_valid <= 1'b0;
		if (!jrstn) begin
			shreg     <= '0;
			old_shift <= 1'b0;
			chain_sel <= DBG_REG_A;
		end else if (tck_rise) begin
			// tap enters shift-dr one edge before data is valid on tdi
			if (old_shift)
				shreg <= {s_tdi, shreg[DR_WIDTH-1:1]}; // lsb first, new bit at the top
			if (s_ce1 || s_ce2)
				chain_sel <= s_ce2 ? DBG_REG_B : DBG_REG_A;
			if (s_update)
				dr_valid <= 1'b1;
			old_shift <= s_shift;
		end
	end

	// word handed down, taken before this edge's shift
	always_ff @(posedge clk48m) begin
		if (tck_rise && s_update) begin
			dr_word <= shreg;
			dr_sel  <= chain_sel; // select as it stood before this edge
		end
	end

	// update pulses come at tck rate, far apart
	a_valid_single: assert property (@(posedge clk48m) disable iff (!jrstn)
		dr_valid |=> !dr_valid);

endmodule

// File: hdl/tck_sampler.sv
/* tck oversampler */
`timescale 1ns/1ps

module tck_sampler (
	input  logic clk48m,
	input  logic jrstn,
	input  logic jtck,
	input  logic jtdi,
	input  logic jshift,
	input  logic jupdate,
	input  logic jce1,
	input  logic jce2,
	output logic tck_rise, // one cycle, a few clocks after the tck edge
	output logic s_tdi,
	output logic s_shift,
	output logic s_update,
	output logic s_ce1,
	output logic s_ce2
);

	logic [3:0]      tck_shift; // tck history, [0] newest
	logic [2:0][4:0] pin_shift; // {tdi, shift, update, ce1, ce2} per stage

	// tck chain and edge detect at taps 3/2
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tck_shift <= '0;
			tck_rise  <= 1'b0;
		end else begin
			tck_shift <= {tck_shift[2:0], jtck};
			tck_rise  <= ~tck_shift[3] & tck_shift[2]; // low then high, a bit past the edge
		end
	end

	// control pins ride alongside the tck samples
	always_ff @(posedge clk48m) begin
		pin_shift <= {pin_shift[1:0], {jtdi, jshift, jupdate, jce1, jce2}};
		// tap 2 lines up with the tck sample that made the edge
		{s_tdi, s_shift, s_update, s_ce1, s_ce2} <= pin_shift[2];
	end

	// tck is oversampled, so an edge never yields back to back pulses
	a_rise_single: assert property (@(posedge clk48m) disable iff (!jrstn)
		tck_rise |=> !tck_rise);

endmodule

// File: hdl/jtag_dbg_pkg.sv
/* jtag debug register path, shared types */

package jtag_dbg_pkg;

	// which scan chain delivered the word
	typedef enum logic {
		DBG_REG_A = 1'b0, // jce1 chain, IR 0x32
		DBG_REG_B = 1'b1  // jce2 chain, IR 0x38
	} dbg_reg_e;

	// wishbone write master states
	typedef enum logic {
		WB_IDLE = 1'b0, // no cycle open
		WB_BUS  = 1'b1  // cyc/stb up, waiting on ack
	} wb_state_e;

	// mailbox word addresses
	localparam logic DBG_ADR_A = 1'b0; // dbg_reg_a
	localparam logic DBG_ADR_B = 1'b1; // dbg_reg_b

	// default data register width, anything from 8 up works
	localparam int DBG_DR_WIDTH_DEF = 32;

endpackage
